//--- logic/cpu_pkg.sv
// shared types for the 6801-subset core; modules refer to them as cpu_pkg::name
`default_nettype none

package cpu_pkg;

    // operand mux source
    typedef enum logic [3:0] {
        RMUX_A,
        RMUX_B,
        RMUX_D,
        RMUX_X,
        RMUX_S,
        RMUX_PC,
        RMUX_EA,
        RMUX_CC,
        RMUX_ONE,
        RMUX_ZERO,
        RMUX_MD
    } rmux_sel_e;

    // writeback destination
    typedef enum logic [3:0] {
        LD_NONE,
        LD_A,
        LD_B,
        LD_D,
        LD_X,
        LD_S,
        LD_MD,
        LD_EA,
        LD_CC,
        LD_PC
    } ld_sel_e;

    // flag update patterns
    typedef enum logic [4:0] {
        CC_NONE,
        CC_NZVC,
        CC_N0ZVC,
        CC_NZV,
        CC_Z,
        CC_C,
        CC_NZV0,
        CC_N0Z1V0C0,
        CC_NZV0C1,
        CC_NZV0C0,
        CC_HNZVC,
        CC_I0,
        CC_I1,
        CC_C0,
        CC_C1,
        CC_V0,
        CC_V1
    } cc_sel_e;

    typedef enum logic [1:0] {
        EA_PC,
        EA_S,
        EA_EA
    } ea_sel_e;

    typedef enum logic [1:0] {
        OPND_NONE,
        OPND_LD0,
        OPND_LD1
    } opnd_sel_e;

    typedef enum logic [2:0] {
        ALU_PASS,   // result is op1
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_INC
    } alu_op_e;

    // one micro-cycle of control
    typedef struct packed {
        rmux_sel_e rmux_sel;
        ld_sel_e   ld_sel;
        cc_sel_e   cc_sel;
        ea_sel_e   ea_sel;
        opnd_sel_e opnd_sel;
        alu_op_e   alu_op;
        logic      byte_op;   // flags from bit 7 instead of bit 15
        logic      fetch;     // din into md
        logic      md_shift;  // keep previous byte as md high
        logic      branch;    // sign-extend md low byte
        logic      brlatch;
        logic      inc_pc;
        logic      we;
        logic      op0inv;
    } ctrl_t;

    // accumulator group view, 80-FF
    typedef struct packed {
        logic       grp;
        logic       acc_b;
        logic [1:0] mode;     // imm, dir, idx, ext
        logic [3:0] op;
    } op_alu_t;

    // relative branch view, 20-2F
    typedef struct packed {
        logic [3:0] cls;
        logic [3:0] cond;
    } op_br_t;

    typedef union packed {
        op_alu_t alu;
        op_br_t  br;
    } opcode_u;

    typedef struct packed {
        logic h;
        logic i;
        logic n;
        logic z;
        logic v;
        logic c;
    } flags_t;

    typedef struct packed {
        logic [15:0] val;
        logic        h;
        logic [3:0]  nzvc;
    } alu_res_t;

    localparam logic [1:0] MODE_IMM = 2'b00;
    localparam logic [1:0] MODE_EXT = 2'b11;
    localparam logic [3:0] OP_SUB   = 4'h0;
    localparam logic [3:0] OP_AND   = 4'h4;
    localparam logic [3:0] OP_LDA   = 4'h6;
    localparam logic [3:0] OP_STA   = 4'h7;
    localparam logic [3:0] OP_ADD   = 4'hb;
    localparam logic [3:0] BR_CLASS = 4'h2;
    localparam logic [7:0] OPC_ABA  = 8'h1b;
    localparam logic [7:0] OPC_CLC  = 8'h0c;
    localparam logic [7:0] OPC_SEC  = 8'h0d;

endpackage

`default_nettype wire

//--- logic/cpu_decode.sv
// micro-sequencer; turns the fetched opcode and step count into the per-cycle control word
`default_nettype none

module cpu_decode (
    input  logic             clk,
    input  logic             rst,
    input  logic             cen,
    input  logic [15:0]      md,
    input  logic             brok,
    output cpu_pkg::ctrl_t   ctrl,
    output cpu_pkg::alu_op_e alu_op
);

    logic [2:0]         step;
    logic               last;      // final cycle of this instruction
    cpu_pkg::opcode_u   ir;
    cpu_pkg::opcode_u   op;
    logic               is_br;
    logic               is_imm;
    logic               is_st;
    cpu_pkg::rmux_sel_e acc_rmux;
    cpu_pkg::ld_sel_e   acc_ld;
    cpu_pkg::alu_op_e   imm_alu;
    cpu_pkg::cc_sel_e   imm_cc;

    // opcode sits in md during step 1, in ir afterwards
    assign op = (step == 3'd1) ? md[7:0] : ir;

    assign is_br  = op.br.cls == cpu_pkg::BR_CLASS;
    assign is_imm = op.alu.grp && op.alu.mode == cpu_pkg::MODE_IMM &&
                    (op.alu.op inside {cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                                       cpu_pkg::OP_LDA, cpu_pkg::OP_ADD});
    assign is_st  = op.alu.grp && op.alu.mode == cpu_pkg::MODE_EXT &&
                    op.alu.op == cpu_pkg::OP_STA;

    assign acc_rmux = op.alu.acc_b ? cpu_pkg::RMUX_B : cpu_pkg::RMUX_A;
    assign acc_ld   = op.alu.acc_b ? cpu_pkg::LD_B : cpu_pkg::LD_A;

    always_comb begin
        case (op.alu.op)
            cpu_pkg::OP_SUB: begin
                imm_alu = cpu_pkg::ALU_SUB;
                imm_cc  = cpu_pkg::CC_NZVC;
            end
            cpu_pkg::OP_AND: begin
                imm_alu = cpu_pkg::ALU_AND;
                imm_cc  = cpu_pkg::CC_NZV0;
            end
            cpu_pkg::OP_ADD: begin
                imm_alu = cpu_pkg::ALU_ADD;
                imm_cc  = cpu_pkg::CC_HNZVC;
            end
            default: begin   // lda
                imm_alu = cpu_pkg::ALU_PASS;
                imm_cc  = cpu_pkg::CC_NZV0;
            end
        endcase
    end

    always_comb begin
        ctrl         = '0;
        ctrl.byte_op = 1'b1;
        last         = 1'b1;
        if (step == 3'd0) begin   // opcode fetch
            ctrl.fetch  = 1'b1;
            ctrl.inc_pc = 1'b1;
            last        = 1'b0;
        end else if (is_imm || op == cpu_pkg::OPC_ABA) begin   // aba carries the adda fields
            case (step)
                3'd1: begin
                    ctrl.fetch    = is_imm;   // immediate byte
                    ctrl.inc_pc   = is_imm;
                    ctrl.rmux_sel = acc_rmux;
                    ctrl.opnd_sel = cpu_pkg::OPND_LD0;
                    last          = 1'b0;
                end
                3'd2: begin
                    ctrl.rmux_sel = is_imm ? cpu_pkg::RMUX_MD : cpu_pkg::RMUX_B;
                    ctrl.opnd_sel = cpu_pkg::OPND_LD1;
                    last          = 1'b0;
                end
                default: begin
                    ctrl.ld_sel = acc_ld;
                    ctrl.alu_op = imm_alu;
                    ctrl.cc_sel = imm_cc;
                end
            endcase
        end else if (is_st) begin
            case (step)
                3'd1, 3'd2: begin   // address high, then low
                    ctrl.fetch    = 1'b1;
                    ctrl.md_shift = step == 3'd2;
                    ctrl.inc_pc   = 1'b1;
                    last          = 1'b0;
                end
                3'd3: begin
                    ctrl.rmux_sel = cpu_pkg::RMUX_MD;
                    ctrl.opnd_sel = cpu_pkg::OPND_LD1;
                    last          = 1'b0;
                end
                3'd4: begin
                    ctrl.ld_sel  = cpu_pkg::LD_EA;
                    ctrl.byte_op = 1'b0;
                    last         = 1'b0;
                end
                default: begin
                    ctrl.ea_sel   = cpu_pkg::EA_EA;
                    ctrl.rmux_sel = acc_rmux;   // selects dout
                    ctrl.we       = 1'b1;
                end
            endcase
        end else if (is_br) begin
            case (step)
                3'd1: begin
                    ctrl.brlatch = 1'b1;   // md still holds the opcode
                    ctrl.fetch   = 1'b1;
                    ctrl.inc_pc  = 1'b1;
                    last         = 1'b0;
                end
                3'd2: begin   // not taken ends here
                    ctrl.branch   = brok;
                    ctrl.rmux_sel = cpu_pkg::RMUX_PC;
                    ctrl.opnd_sel = brok ? cpu_pkg::OPND_LD0 : cpu_pkg::OPND_NONE;
                    last          = !brok;
                end
                3'd3: begin
                    ctrl.rmux_sel = cpu_pkg::RMUX_MD;
                    ctrl.opnd_sel = cpu_pkg::OPND_LD1;
                    last          = 1'b0;
                end
                default: begin
                    ctrl.alu_op  = cpu_pkg::ALU_ADD;
                    ctrl.byte_op = 1'b0;
                    ctrl.ld_sel  = cpu_pkg::LD_PC;
                end
            endcase
        end else if (op == cpu_pkg::OPC_CLC) begin
            ctrl.cc_sel = cpu_pkg::CC_C0;
        end else if (op == cpu_pkg::OPC_SEC) begin
            ctrl.cc_sel = cpu_pkg::CC_C1;
        end
    end

    assign alu_op = ctrl.alu_op;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            step <= 3'd0;
            ir   <= '0;
        end else if (cen) begin
            step <= last ? 3'd0 : step + 3'd1;
            if (step == 3'd1) begin
                ir <= md[7:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/cpu_alu.sv
// combinational execute stage; result and 6800-style flags for byte or word operations
`default_nettype none

module cpu_alu (
    input  logic [15:0]       op0,
    input  logic [15:0]       op1,
    input  cpu_pkg::alu_op_e  alu_op,
    input  logic              byte_op,
    output cpu_pkg::alu_res_t res
);

    logic [15:0] opb;    // second operand, one for inc
    logic [15:0] r;
    logic        sa;
    logic        sb;
    logic        sr;
    logic        zero;
    logic        hc;
    logic        v;
    logic        c;

    assign opb = (alu_op == cpu_pkg::ALU_INC) ? 16'd1 : op1;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_INC: r = op0 + opb;
            cpu_pkg::ALU_SUB: r = op0 - opb;
            cpu_pkg::ALU_AND: r = op0 & opb;
            default:          r = opb;
        endcase
    end

    // sign bits at the selected width
    assign sa   = byte_op ? op0[7] : op0[15];
    assign sb   = byte_op ? opb[7] : opb[15];
    assign sr   = byte_op ? r[7] : r[15];
    assign zero = byte_op ? (r[7:0] == 8'd0) : (r == 16'd0);
    assign hc   = (op0[3] & opb[3]) | (opb[3] & ~r[3]) | (~r[3] & op0[3]);

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_INC: begin
                v = (sa & sb & ~sr) | (~sa & ~sb & sr);
                c = (sa & sb) | (sb & ~sr) | (~sr & sa);
            end
            cpu_pkg::ALU_SUB: begin
                v = (sa & ~sb & ~sr) | (~sa & sb & sr);
                c = (~sa & sb) | (sb & sr) | (sr & ~sa);   // borrow
            end
            default: begin
                v = 1'b0;
                c = 1'b0;
            end
        endcase
    end

    assign res = '{val: r, h: hc, nzvc: {sr, zero, v, c}};

endmodule

`default_nettype wire

//--- logic/cpu_regs.sv
// register file and writeback; operand latches, flag updates and branch condition latch
`default_nettype none

module cpu_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  cpu_pkg::ctrl_t    ctrl,
    input  logic [7:0]        din,
    input  cpu_pkg::alu_res_t res,
    output logic [15:0]       md,
    output logic [15:0]       op0,
    output logic [15:0]       op1,
    output logic [15:0]       addr,
    output logic [7:0]        dout,
    output logic              brok
);

    logic [7:0]       a;
    logic [7:0]       b;
    logic [15:0]      x;
    logic [15:0]      s;
    logic [15:0]      pc;
    logic [15:0]      ea;
    logic [15:0]      rmux;
    cpu_pkg::flags_t  flags;

    always_comb begin
        case (ctrl.rmux_sel)
            cpu_pkg::RMUX_A:    rmux = {8'd0, a};
            cpu_pkg::RMUX_B:    rmux = {8'd0, b};
            cpu_pkg::RMUX_D:    rmux = {a, b};
            cpu_pkg::RMUX_X:    rmux = x;
            cpu_pkg::RMUX_S:    rmux = s;
            cpu_pkg::RMUX_PC:   rmux = pc;
            cpu_pkg::RMUX_EA:   rmux = ea;
            cpu_pkg::RMUX_CC:   rmux = {8'd0, 2'b11, flags};
            cpu_pkg::RMUX_ONE:  rmux = 16'd1;
            cpu_pkg::RMUX_ZERO: rmux = 16'd0;
            default:            rmux = md;
        endcase
    end

    always_comb begin
        case (ctrl.ea_sel)
            cpu_pkg::EA_S:  addr = s;
            cpu_pkg::EA_EA: addr = ea;
            default:        addr = pc;
        endcase
    end

    assign dout = (ctrl.rmux_sel == cpu_pkg::RMUX_B) ? b : a;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            a     <= 8'd0;
            b     <= 8'd0;
            x     <= 16'd0;
            s     <= 16'd0;
            pc    <= 16'd0;   // no reset vector in this core
            ea    <= 16'd0;
            md    <= 16'd0;
            op0   <= 16'd0;
            op1   <= 16'd0;
            flags <= '{h: 1'b0, i: 1'b1, n: 1'b0, z: 1'b0, v: 1'b0, c: 1'b0};
        end else if (cen) begin
            if (ctrl.fetch) begin
                md[7:0]  <= din;
                md[15:8] <= ctrl.md_shift ? md[7:0] : 8'd0;
            end
            if (ctrl.branch) begin
                md[15:8] <= {8{md[7]}};   // relative offset
            end
            case (ctrl.opnd_sel)
                cpu_pkg::OPND_LD0: op0 <= {16{ctrl.op0inv}} ^ rmux;
                cpu_pkg::OPND_LD1: op1 <= rmux;
                default: ;
            endcase
            case (ctrl.cc_sel)
                cpu_pkg::CC_NZVC:     {flags.n, flags.z, flags.v, flags.c} <= res.nzvc;
                cpu_pkg::CC_N0ZVC:    {flags.n, flags.z, flags.v, flags.c} <=
                                      {1'b0, res.nzvc[2:0]};
                cpu_pkg::CC_NZV:      {flags.n, flags.z, flags.v} <= res.nzvc[3:1];
                cpu_pkg::CC_Z:        flags.z <= res.nzvc[2];
                cpu_pkg::CC_C:        flags.c <= res.nzvc[0];
                cpu_pkg::CC_NZV0:     {flags.n, flags.z, flags.v} <= {res.nzvc[3:2], 1'b0};
                cpu_pkg::CC_N0Z1V0C0: {flags.n, flags.z, flags.v, flags.c} <= 4'b0100;
                cpu_pkg::CC_NZV0C1:   {flags.n, flags.z, flags.v, flags.c} <=
                                      {res.nzvc[3:2], 2'b01};
                cpu_pkg::CC_NZV0C0:   {flags.n, flags.z, flags.v, flags.c} <=
                                      {res.nzvc[3:2], 2'b00};
                cpu_pkg::CC_HNZVC:    {flags.h, flags.n, flags.z, flags.v, flags.c} <=
                                      {res.h, res.nzvc};
                cpu_pkg::CC_I0:       flags.i <= 1'b0;
                cpu_pkg::CC_I1:       flags.i <= 1'b1;
                cpu_pkg::CC_C0:       flags.c <= 1'b0;
                cpu_pkg::CC_C1:       flags.c <= 1'b1;
                cpu_pkg::CC_V0:       flags.v <= 1'b0;
                cpu_pkg::CC_V1:       flags.v <= 1'b1;
                default: ;
            endcase
            case (ctrl.ld_sel)
                cpu_pkg::LD_A:  a <= res.val[7:0];
                cpu_pkg::LD_B:  b <= res.val[7:0];
                cpu_pkg::LD_D:  {a, b} <= res.val;
                cpu_pkg::LD_X:  x <= res.val;
                cpu_pkg::LD_S:  s <= res.val;
                cpu_pkg::LD_MD: md <= res.val;
                cpu_pkg::LD_EA: ea <= res.val;
                cpu_pkg::LD_CC: flags <= res.val[5:0];
                cpu_pkg::LD_PC: pc <= res.val;
                default: ;
            endcase
            if (ctrl.inc_pc) begin
                pc <= pc + 16'd1;
            end
        end
    end

    // condition code taken from the opcode still held in md
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            brok <= 1'b0;
        end else if (cen && ctrl.brlatch) begin
            case (md[3:0])
                4'h0: brok <= 1'b1;                                 // bra
                4'h1: brok <= 1'b0;                                 // brn
                4'h2: brok <= !(flags.c | flags.z);                 // bhi
                4'h3: brok <= flags.c | flags.z;                    // bls
                4'h4: brok <= !flags.c;                             // bcc
                4'h5: brok <= flags.c;                              // bcs
                4'h6: brok <= !flags.z;                             // bne
                4'h7: brok <= flags.z;                              // beq
                4'h8: brok <= !flags.v;                             // bvc
                4'h9: brok <= flags.v;                              // bvs
                4'ha: brok <= !flags.n;                             // bpl
                4'hb: brok <= flags.n;                              // bmi
                4'hc: brok <= !(flags.n ^ flags.v);                 // bge
                4'hd: brok <= flags.n ^ flags.v;                    // blt
                4'he: brok <= !(flags.z | (flags.n ^ flags.v));     // bgt
                default: brok <= flags.z | (flags.n ^ flags.v);     // ble
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
// core top level; connects decoder, ALU and register file to the external byte bus
`default_nettype none

module cpu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:0]  din,
    output logic [15:0] addr,
    output logic [7:0]  dout,
    output logic        we
);

    cpu_pkg::ctrl_t    ctrl;
    cpu_pkg::alu_op_e  alu_op;
    cpu_pkg::alu_res_t res;
    logic [15:0]       md;
    logic [15:0]       op0;
    logic [15:0]       op1;
    logic              brok;

    assign we = ctrl.we;   // memory qualifies with cen

    cpu_decode cpu_decode_inst (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .md     (md),
        .brok   (brok),
        .ctrl   (ctrl),
        .alu_op (alu_op)
    );

    cpu_alu cpu_alu_inst (
        .op0     (op0),
        .op1     (op1),
        .alu_op  (alu_op),
        .byte_op (ctrl.byte_op),
        .res     (res)
    );

    cpu_regs cpu_regs_inst (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .ctrl (ctrl),
        .din  (din),
        .res  (res),
        .md   (md),
        .op0  (op0),
        .op1  (op1),
        .addr (addr),
        .dout (dout),
        .brok (brok)
    );

endmodule

`default_nettype wire

//--- verif/cpu_checker.sv
// testbench checker; models each program at instruction level and compares the DUT's bus writes
`default_nettype none

module cpu_checker (
    input  logic        clk,
    input  logic        start,        // load image into the model
    input  logic        done,         // close the current test
    input  logic        cen,
    input  logic        we,
    input  logic [15:0] addr,
    input  logic [7:0]  dout,
    input  logic [7:0]  image [256],
    output logic [15:0] halt_addr,
    output int          model_instr,
    output int          test_count,
    output int          fail_count,
    output int          error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    string       test_name;
    logic [15:0] exp_addr [64];
    logic [7:0]  exp_data [64];
    int          exp_n;
    int          got;
    int          test_err;
    int          tests = 0;
    int          fails = 0;
    int          errors = 0;
    int          n_instr = 0;
    logic [15:0] halt_pc = 16'hffff;
    logic        active = 1'b0;
    logic        prev_cen;
    logic [15:0] prev_addr;
    logic [7:0]  prev_dout;

    assign halt_addr   = halt_pc;
    assign model_instr = n_instr;
    assign test_count  = tests;
    assign fail_count  = fails;
    assign error_count = errors;

    // standard 6800 branch conditions
    function automatic logic cond_taken(input logic [3:0] cc, input logic n, input logic z,
                                        input logic v, input logic c);
        case (cc)
            4'h0: return 1'b1;
            4'h1: return 1'b0;
            4'h2: return !c && !z;
            4'h3: return c || z;
            4'h4: return !c;
            4'h5: return c;
            4'h6: return !z;
            4'h7: return z;
            4'h8: return !v;
            4'h9: return v;
            4'ha: return !n;
            4'hb: return n;
            4'hc: return n == v;
            4'hd: return n != v;
            4'he: return !z && (n == v);
            default: return z || (n != v);
        endcase
    endfunction

    // instruction-level interpreter; fills the expected store list
    function automatic void run_model();
        logic [15:0] pc;
        logic [7:0]  a;
        logic [7:0]  b;
        logic [7:0]  op;
        logic [7:0]  m;
        logic [7:0]  r;
        logic [8:0]  sum;
        logic        n;
        logic        z;
        logic        v;
        logic        c;
        logic        taken;
        pc = 16'd0;
        a = 8'd0;
        b = 8'd0;
        {n, z, v, c} = 4'b0000;
        exp_n = 0;
        n_instr = 0;
        halt_pc = 16'hffff;
        for (int steps = 0; steps < 1000 && halt_pc == 16'hffff; steps++) begin
            op = image[pc[7:0]];
            m  = image[pc[7:0] + 8'd1];
            case (op)
                8'h86, 8'hc6: begin   // load immediate
                    r = m;
                    {n, z, v} = {r[7], r == 8'd0, 1'b0};
                    if (op == 8'h86) a = r;
                    else b = r;
                    pc = pc + 16'd2;
                end
                8'h8b, 8'h1b: begin   // adda, aba
                    if (op == 8'h1b) m = b;
                    sum = {1'b0, a} + {1'b0, m};
                    r = sum[7:0];
                    c = sum[8];
                    v = (a[7] == m[7]) && (r[7] != a[7]);
                    {n, z} = {r[7], r == 8'd0};
                    a = r;
                    pc = pc + ((op == 8'h1b) ? 16'd1 : 16'd2);
                end
                8'h80: begin
                    r = a - m;
                    c = m > a;   // borrow
                    v = (a[7] != m[7]) && (r[7] != a[7]);
                    {n, z} = {r[7], r == 8'd0};
                    a = r;
                    pc = pc + 16'd2;
                end
                8'h84: begin
                    r = a & m;
                    {n, z, v} = {r[7], r == 8'd0, 1'b0};
                    a = r;
                    pc = pc + 16'd2;
                end
                8'h0c, 8'h0d: begin
                    c = op[0];
                    pc = pc + 16'd1;
                end
                8'hb7, 8'hf7: begin
                    exp_addr[exp_n] = {m, image[pc[7:0] + 8'd2]};
                    exp_data[exp_n] = (op == 8'hb7) ? a : b;
                    exp_n++;
                    pc = pc + 16'd3;
                end
                default: begin
                    if (op[7:4] == 4'h2) begin
                        taken = cond_taken(op[3:0], n, z, v, c);
                        if (taken && m == 8'hfe) halt_pc = pc;
                        else pc = pc + 16'd2 + (taken ? {{8{m[7]}}, m} : 16'd0);
                    end else begin
                        pc = pc + 16'd1;   // nop
                    end
                end
            endcase
            if (halt_pc == 16'hffff) n_instr++;
        end
    endfunction

    always @(posedge clk) begin
        if (start) begin
            run_model();
            got = 0;
            test_err = 0;
            active = 1'b1;
            prev_cen = 1'b1;
        end else if (done && active) begin
            if (got < exp_n) begin
                $display("test %s: only %0d of %0d expected stores appeared", test_name, got,
                         exp_n);
                test_err++;
                errors++;
            end
            tests++;
            if (test_err != 0) fails++;
            $display("test %-16s %s (%0d stores)", test_name, (test_err == 0) ? "ok" : "FAIL",
                     got);
            active = 1'b0;
        end else if (active) begin
            if (!prev_cen && (addr != prev_addr || dout != prev_dout)) begin
                $display("test %s: bus changed while cen was low", test_name);
                test_err++;
                errors++;
            end
            if (we && cen) begin
                if (got >= exp_n) begin
                    $display("test %s: extra store to %04h", test_name, addr);
                    test_err++;
                    errors++;
                end else begin
                    if (addr != exp_addr[got] || dout != exp_data[got]) begin
                        $display("MISMATCH %s store %0d expected %04h:%02h actual %04h:%02h",
                                 test_name, got, exp_addr[got], exp_data[got], addr, dout);
                        test_err++;
                        errors++;
                    end
                    got++;
                end
            end
            prev_cen = cen;
            prev_addr = addr;
            prev_dout = dout;
        end
    end

endmodule

`default_nettype wire

//--- verif/cpu_tb.sv
// testbench top; memory model, program images, reset and cen stalls around the core
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        rst;
    logic        cen;
    logic [7:0]  din;
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        we;
    logic        start;
    logic        done;
    logic        load;
    logic [7:0]  mem [256];
    logic [7:0]  img [256];
    logic [7:0]  wp;      // image write pointer
    logic [15:0] halt_addr;
    int          model_instr;
    int          test_count;
    int          fail_count;
    int          error_count;
    int          seed;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    cpu_top cpu_top_inst (
        .clk  (clk),
        .rst  (rst),
        .cen  (cen),
        .din  (din),
        .addr (addr),
        .dout (dout),
        .we   (we)
    );

    cpu_checker cpu_checker_inst (
        .clk         (clk),
        .start       (start),
        .done        (done),
        .cen         (cen),
        .we          (we),
        .addr        (addr),
        .dout        (dout),
        .image       (img),
        .halt_addr   (halt_addr),
        .model_instr (model_instr),
        .test_count  (test_count),
        .fail_count  (fail_count),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign din = mem[addr[7:0]];   // async read

    always @(posedge clk) begin
        if (load) begin
            for (int i = 0; i < 256; i++) mem[i] <= img[i];
        end else if (we && cen) begin
            mem[addr[7:0]] <= dout;
        end
    end

    // cycle budget of the running test
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout: test %s never reached its final loop in %0d cycles",
                     cpu_checker_inst.test_name, cycle_limit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    task automatic put_byte(input logic [7:0] value);
        img[wp] = value;
        wp = wp + 8'd1;
    endtask

    task automatic put_pair(input logic [7:0] opcode, input logic [7:0] operand);
        put_byte(opcode);
        put_byte(operand);
    endtask

    task automatic clear_image();
        for (int i = 0; i < 256; i++) img[i] = 8'h00;
        wp = 8'd0;
    endtask

    task automatic put_store(input logic acc_b, input logic [7:0] lo);
        put_byte(acc_b ? 8'hf7 : 8'hb7);
        put_byte(8'h00);
        put_byte(lo);
    endtask

    task automatic build_load_store();
        clear_image();
        put_pair(8'h86, 8'h12);
        put_pair(8'hc6, 8'h34);
        put_store(1'b0, 8'h80);
        put_store(1'b1, 8'h81);
        put_pair(8'h86, 8'hff);
        put_store(1'b0, 8'h82);
        put_pair(8'h20, 8'hfe);
    endtask

    task automatic build_alu();
        clear_image();
        put_pair(8'h86, 8'h7f);
        put_pair(8'h8b, 8'h01);   // signed overflow
        put_store(1'b0, 8'h83);
        put_pair(8'h80, 8'h81);   // borrow
        put_store(1'b0, 8'h84);
        put_pair(8'h84, 8'h3c);
        put_store(1'b0, 8'h85);
        put_pair(8'hc6, 8'hc8);
        put_byte(8'h1b);
        put_store(1'b0, 8'h86);
        put_store(1'b1, 8'h87);
        put_pair(8'h20, 8'hfe);
    endtask

    // flag setup variant, branch over a marker store, then a second marker
    task automatic build_branch(input logic [3:0] cond, input int variant);
        clear_image();
        put_pair(8'hc6, 8'h5a);
        case (variant)
            0: begin
                put_pair(8'h86, 8'h00);
                put_byte(8'h0d);
            end
            1: begin
                put_pair(8'h86, 8'h7f);
                put_pair(8'h8b, 8'h01);
            end
            2: begin
                put_pair(8'h86, 8'h40);
                put_byte(8'h0c);
            end
            default: begin
                put_pair(8'h86, 8'h80);
                put_byte(8'h0d);
            end
        endcase
        put_pair({4'h2, cond}, 8'h03);
        put_store(1'b1, 8'h90);
        put_store(1'b1, 8'h91);
        put_pair(8'h20, 8'hfe);
    endtask

    task automatic build_random();
        logic [3:0] kind;
        clear_image();
        for (int i = 0; i < 20; i++) begin
            kind = 4'($random(seed));
            case (kind)
                4'd0, 4'd1: put_pair(8'h86, 8'($random(seed)));
                4'd2: put_pair(8'hc6, 8'($random(seed)));
                4'd3: put_pair(8'h8b, 8'($random(seed)));
                4'd4: put_pair(8'h80, 8'($random(seed)));
                4'd5: put_pair(8'h84, 8'($random(seed)));
                4'd6: put_byte(8'h1b);
                4'd7: put_byte(8'h0c);
                4'd8: put_byte(8'h0d);
                default: put_store(kind[0], 8'h80 | 8'($random(seed)));
            endcase
        end
        put_pair(8'h20, 8'hfe);
    endtask

    // reset, run until the final loop has spun for 20 cycles, then close the test
    task automatic run_test(input string name, input logic stall);
        int halted;
        cpu_checker_inst.test_name = name;
        cycle_count = 0;
        rst = 1'b1;
        cen = 1'b1;
        start = 1'b1;
        load = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        load = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        cycle_count = 0;
        cycle_limit = model_instr * 5 * (stall ? 4 : 1) + 200;
        halted = 0;
        while (halted < 20) begin
            @(posedge clk);
            #1;
            if (halted > 0 || addr == halt_addr) halted++;
            cen = stall ? (($random(seed) & 3) != 0) : 1'b1;
        end
        cen = 1'b1;
        done = 1'b1;
        @(posedge clk);
        #1;
        done = 1'b0;
    endtask

    initial begin
        seed = 84533;
        rst = 1'b1;
        cen = 1'b1;
        start = 1'b0;
        done = 1'b0;
        load = 1'b0;
        clear_image();
        build_load_store();
        run_test("load_store", 1'b0);
        build_alu();
        run_test("alu_ops", 1'b0);
        for (int cond = 0; cond < 16; cond++) begin
            for (int variant = 0; variant < 4; variant++) begin
                build_branch(4'(cond), variant);
                run_test($sformatf("branch_%0h_v%0d", cond, variant), 1'b0);
            end
        end
        build_random();
        run_test("random", 1'b0);
        run_test("random_stall", 1'b1);   // same image under stalls
        $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
logic/cpu_pkg.sv
logic/cpu_decode.sv
logic/cpu_alu.sv
logic/cpu_regs.sv
logic/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timescale 1ns/100ps -f verilog.f --top-module cpu_tb -o cpu_sim
	@out=$$(./obj_dir/cpu_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
